// File: testbench/eeg_cmd_patterns.txt
// chain cmd_dat info_cmd mem_cfg layer_cfg, one command per row, all hex
// chain 1 means the row is sent on the cycle right after the previous row
0 12352A70 001 1400048CA9C00000000000 0000000000000000
0 55E52341 002 1500048CA9D57923400000 0000000000000000
0 3C597B02 004 252DC48CA9D57923400000 000000000F000280
0 FFFF0D75 020 252DC48CA9D57923400000 0000000F4F00028F
0 0001AF16 040 252DC48CA9D57923400000 0000000F4F2F1AAF
0 3A54281C 000 252DC48CA9D57923400000 40A174AF4F2F1AAF
0 FEDA0F0D 000 252DFFB43C157923400000 40A174AF4F2F1AAF
0 FFF8001E 000 252DFFB43C3FFE00100000 40A174AF4F2F1AAF
0 AD80155F 000 252DFFB43C3FFE001AD955 40A174AF4F2F1AAF
0 00028003 008 0A2DFFB43C3FFE001AD955 40A174AF4F2F1AAF
0 000C3004 010 30EDFFB43C3FFE001AD955 40A174AF4F2F1AAF
0 00000607 080 30D9FFB43C3FFE001AD955 40A174AF4F2F1AAF
0 0001E408 100 0791FFB43C3FFE001AD955 40A174AF4F2F1AAF
0 FFFFFFF9 000 0791FFB43C3FFE001AD955 40A174AF4F2F1AAF
0 00060021 002 0611FFB43C0000002AD955 40A174AF4F2F1AAF
0 08000101 002 0451FFB43C0200010AD955 40A174AF4F2F1AAF
0 001A0001 002 0491FFB43C0006000AD955 40A174AF4F2F1AAF
0 1234567A 000 0491FFB43C0006000AD955 40A174AF4F2F1AAF
0 0000000B 000 0491FFB43C0006000AD955 40A174AF4F2F1AAF
0 00000255 020 0491FFB43C0006000AD955 40A174AA8F2F1AA0
0 4563789D 000 0491D159E24006000AD955 40A174AA8F2F1AA0
1 ABC70120 001 1C91EAF0048006000AD955 40A174AA8F2F1AA0

// File: project.f
hdl/eeg_cmd_pkg.sv
hdl/eeg_cfg_pkg.sv
hdl/eeg_op_decode.sv
hdl/eeg_mem_cfg.sv
hdl/eeg_layer_cfg.sv
hdl/eeg_cmd_top.sv
testbench/eeg_cmd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module eeg_cmd_tb -o eeg_cmd_sim

output="$(./obj_dir/eeg_cmd_sim)"
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1

// File: testbench/eeg_cmd_tb.sv
// Reads testbench/eeg_cmd_patterns.txt relative to the project root; chained rows go back to back
`default_nettype none
`timescale 1ns/10ps

module eeg_cmd_tb;

    import eeg_cmd_pkg::*;
    import eeg_cfg_pkg::*;

    localparam int pat_num      = 22;
    localparam int pat_cols     = 5;
    localparam int info_timeout = 8;
    localparam int hold_cycles  = 40;

    logic       clk;
    logic       rst_n;
    logic       cmd_vld;
    cmd_word_t  cmd_dat;
    logic       info_vld;
    act_ena_t   info_cmd;
    act_ena_t   act_ena;
    mem_cfg_t   mem_cfg;
    layer_cfg_t layer_cfg;

    logic [127:0] pat_words [0:pat_num*pat_cols-1];
    logic [31:0]  lfsr_state;
    int           value_errors;
    int           other_errors;

    act_ena_t   exp_ena;
    mem_cfg_t   exp_mem;
    layer_cfg_t exp_layer;

    eeg_cmd_top eeg_cmd_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vld   (cmd_vld),
        .cmd_dat   (cmd_dat),
        .info_vld  (info_vld),
        .info_cmd  (info_cmd),
        .act_ena   (act_ena),
        .mem_cfg   (mem_cfg),
        .layer_cfg (layer_cfg)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================
    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int k = 0; k < 32; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[k] = lfsr_state[0];
        end
    endtask

    // Idle cycle with noise on the data bus
    task automatic drive_idle();
        logic [31:0] w;
        random_word(w);
        cmd_vld = 1'b0;
        cmd_dat = w;
    endtask

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        value_errors++;
        $display("error: %s got %h expected %h", name, got, exp);
    endtask

    task automatic check_outputs(input logic vld_exp);
        assert (info_vld === vld_exp)
        else report_value("info_vld", 128'(info_vld), 128'(vld_exp));
        assert (info_cmd === exp_ena)
        else report_value("info_cmd", 128'(info_cmd), 128'(exp_ena));
        assert (act_ena === exp_ena)
        else report_value("act_ena", 128'(act_ena), 128'(exp_ena));
        assert (mem_cfg === exp_mem)
        else report_value("mem_cfg", 128'(mem_cfg), 128'(exp_mem));
        assert (layer_cfg === exp_layer)
        else report_value("layer_cfg", 128'(layer_cfg), 128'(exp_layer));
    endtask

    // Global limit in case a loop misbehaves
    initial begin
        #200000;
        $display("simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int  idx;
        int  lat;
        bit  got;
        bit  driven;

        rst_n        = 1'b0;
        cmd_vld      = 1'b0;
        cmd_dat      = '0;
        lfsr_state   = 32'h906c;
        value_errors = 0;
        other_errors = 0;
        exp_ena      = '0;
        exp_mem      = '0;
        exp_layer    = '0;
        $readmemh("testbench/eeg_cmd_patterns.txt", pat_words);

        // Reset for 4 cycles, outputs must be zero during and after it
        repeat (4) @(negedge clk);
        check_outputs(1'b0);
        rst_n = 1'b1;
        @(negedge clk);
        check_outputs(1'b0);

        idx    = 0;
        driven = 1'b0;
        while (idx < pat_num) begin
            if (!driven) begin
                @(negedge clk);
                cmd_vld = 1'b1;
                cmd_dat = pat_words[idx*pat_cols+1][31:0];
                // Outputs hold until the capturing rising edge
                #1;
                check_outputs(1'b0);
            end

            lat = 0;
            got = 1'b0;
            while (!got && lat < info_timeout) begin
                @(negedge clk);
                lat++;
                if (info_vld === 1'b1) begin
                    got = 1'b1;
                end else begin
                    drive_idle();
                end
            end
            if (!got) begin
                other_errors++;
                $display("no info_vld within %0d cycles of command %0d", info_timeout, idx);
                break;
            end
            assert (lat == 1)
            else begin
                other_errors++;
                $display("info_vld came %0d cycles after command %0d", lat, idx);
            end

            exp_ena   = act_ena_t'(pat_words[idx*pat_cols+2][8:0]);
            exp_mem   = mem_cfg_t'(pat_words[idx*pat_cols+3][85:0]);
            exp_layer = layer_cfg_t'(pat_words[idx*pat_cols+4][62:0]);
            check_outputs(1'b1);

            // Next row chained, so it goes out on this very cycle
            if (idx + 1 < pat_num && pat_words[(idx+1)*pat_cols][0]) begin
                cmd_vld = 1'b1;
                cmd_dat = pat_words[(idx+1)*pat_cols+1][31:0];
                driven  = 1'b1;
            end else begin
                drive_idle();
                driven = 1'b0;
                @(negedge clk);
                check_outputs(1'b0);
            end
            idx++;
        end

        // ==============================
        // Hold with cmd_vld low
        // ==============================
        for (int c = 0; c < hold_cycles; c++) begin
            drive_idle();
            @(negedge clk);
            check_outputs(1'b0);
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/eeg_cmd_top.sv
// One command per cycle with no back-pressure; all outputs update one cycle after cmd_vld
`default_nettype none
`timescale 1ns/10ps

module eeg_cmd_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmd_vld,
    input  wire eeg_cmd_pkg::cmd_word_t cmd_dat,
    output logic                        info_vld,
    output eeg_cmd_pkg::act_ena_t       info_cmd,
    output eeg_cmd_pkg::act_ena_t       act_ena,
    output eeg_cfg_pkg::mem_cfg_t       mem_cfg,
    output eeg_cfg_pkg::layer_cfg_t     layer_cfg
);

    import eeg_cmd_pkg::*;

    opcode_t cmd_op;
    op_hit_t hit;

    // Low nibble of the command word
    assign cmd_op = opcode_t'(cmd_dat[lsb_opcode +: opcode_w]);

    // ==============================
    // Decoder and register banks
    // ==============================
    eeg_op_decode eeg_op_decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_vld  (cmd_vld),
        .cmd_op   (cmd_op),
        .hit      (hit),
        .act_ena  (act_ena),
        .info_vld (info_vld)
    );

    eeg_mem_cfg eeg_mem_cfg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .hit     (hit),
        .cmd_dat (cmd_dat),
        .mem_cfg (mem_cfg)
    );

    eeg_layer_cfg eeg_layer_cfg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hit       (hit),
        .cmd_dat   (cmd_dat),
        .layer_cfg (layer_cfg)
    );

    // Info vector reports the registered enables
    assign info_cmd = act_ena;

endmodule

`default_nettype wire

// File: hdl/eeg_layer_cfg.sv
// Loads on decoder hits only; CONV bit 11 sets resn, flag_vld, stat_vld and wbuf together
`default_nettype none
`timescale 1ns/10ps

module eeg_layer_cfg (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire eeg_cmd_pkg::op_hit_t   hit,
    input  wire eeg_cmd_pkg::cmd_word_t cmd_dat,
    output eeg_cfg_pkg::layer_cfg_t layer_cfg
);

    import eeg_cmd_pkg::*;
    import eeg_cfg_pkg::*;

    logic conv_mode;

    // Single mode bit drives the residual path, flag and stat capture and the weight buffer
    assign conv_mode = cmd_dat[bit_conv_mode];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_cfg <= '0;
        end else begin
            // ==============================
            // Convolution shape
            // ==============================
            if (hit.inf_conv) begin
                layer_cfg.conv_ich <= cmd_dat[lsb_conv_ich +: conv_ich_w];
                layer_cfg.conv_och <= cmd_dat[lsb_conv_och +: conv_och_w];
                layer_cfg.conv_len <= cmd_dat[lsb_conv_len +: conv_len_w];
            end

            // Stride, dilation and weight width
            if (hit.conv) begin
                layer_cfg.strd_fac       <= cmd_dat[lsb_strd_fac +: strd_fac_w];
                layer_cfg.dila_fac       <= cmd_dat[lsb_dila_fac +: dila_fac_w];
                layer_cfg.conv_wei       <= cmd_dat[lsb_conv_wei +: conv_wei_w];
                layer_cfg.flags.resn     <= conv_mode;
                layer_cfg.flags.flag_vld <= conv_mode;
                layer_cfg.flags.stat_vld <= conv_mode;
                layer_cfg.flags.wbuf     <= conv_mode;
            end

            // ==============================
            // Split and output flags
            // ==============================
            if (hit.otoa) begin
                layer_cfg.splt_len   <= cmd_dat[lsb_splt_len +: splt_len_w];
                layer_cfg.flags.relu <= cmd_dat[bit_relu];
                layer_cfg.flags.splt <= cmd_dat[bit_splt];
                layer_cfg.flags.comb <= cmd_dat[bit_comb];
                layer_cfg.flags.flag <= cmd_dat[bit_flag];
            end

            // ==============================
            // Pooling
            // ==============================
            // Max and average bits are independent, both may be set
            if (hit.pool) begin
                layer_cfg.pool_len   <= cmd_dat[lsb_pool_len +: pool_len_w];
                layer_cfg.pool_fac   <= cmd_dat[lsb_pool_fac +: pool_fac_w];
                layer_cfg.flags.maxp <= cmd_dat[bit_maxp];
                layer_cfg.flags.avgp <= cmd_dat[bit_avgp];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeg_mem_cfg.sv
// Loads on decoder hits only; at most one hit is expected per cycle so load order is irrelevant
`default_nettype none
`timescale 1ns/10ps

module eeg_mem_cfg (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire eeg_cmd_pkg::op_hit_t   hit,
    input  wire eeg_cmd_pkg::cmd_word_t cmd_dat,
    output eeg_cfg_pkg::mem_cfg_t   mem_cfg
);

    import eeg_cmd_pkg::*;
    import eeg_cfg_pkg::*;

    logic [wram_sel_w-1:0] wram_sel;
    logic [bank_idx_w-1:0] wram_sel_hot;
    logic                  ld_aram_idx;
    logic                  ld_wram_num;
    logic                  ld_oram_idx;
    logic                  ld_aram_rng;
    logic                  ld_wram_rng;

    // ==============================
    // Load conditions
    // ==============================
    assign ld_aram_idx = hit.itoa | hit.otoa | hit.atow | hit.wtoa | hit.read;
    assign ld_wram_num = hit.atow | hit.wtoa | hit.read;
    assign ld_oram_idx = hit.otoa | hit.stat | hit.read;
    // ITOA and INF_ARAM share the same address and length fields
    assign ld_aram_rng = hit.itoa | hit.inf_aram;
    assign ld_wram_rng = hit.itow | hit.inf_wram;

    // ITOW gives a 2-bit selector, one weight bank per code
    assign wram_sel     = cmd_dat[lsb_wram_sel +: wram_sel_w];
    assign wram_sel_hot = {{(bank_idx_w-1){1'b0}}, 1'b1} << wram_sel;

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_cfg <= '0;
        end else begin
            // Bank selects
            if (ld_aram_idx) begin
                mem_cfg.aram_idx <= cmd_dat[lsb_aram_idx +: bank_idx_w];
            end
            if (hit.itow) begin
                mem_cfg.wram_idx <= wram_sel_hot;
            end else if (ld_wram_num) begin
                mem_cfg.wram_idx <= cmd_dat[lsb_wram_idx +: bank_idx_w];
            end
            if (ld_oram_idx) begin
                mem_cfg.oram_idx <= cmd_dat[lsb_oram_idx +: bank_idx_w];
            end
            if (hit.otoa) begin
                mem_cfg.omux_idx <= cmd_dat[lsb_omux_idx +: bank_idx_w];
            end

            // Activation RAM window
            if (ld_aram_rng) begin
                mem_cfg.aram_add <= cmd_dat[lsb_aram_add +: aram_add_w];
                mem_cfg.aram_len <= cmd_dat[lsb_aram_len +: aram_add_w];
            end

            // Weight RAM window
            if (ld_wram_rng) begin
                mem_cfg.wram_add <= cmd_dat[lsb_wram_add +: wram_add_w];
                mem_cfg.wram_len <= cmd_dat[lsb_wram_len +: wram_add_w];
            end

            // Output RAM window, only set by INF_ORAM
            if (hit.inf_oram) begin
                mem_cfg.oram_add <= cmd_dat[lsb_oram_add +: oram_add_w];
                mem_cfg.oram_len <= cmd_dat[lsb_oram_len +: oram_add_w];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeg_op_decode.sv
// Hits are combinational from cmd_vld and the opcode; enables and info valid follow one cycle later
`default_nettype none
`timescale 1ns/10ps

module eeg_op_decode (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cmd_vld,
    input  wire eeg_cmd_pkg::opcode_t cmd_op,
    output eeg_cmd_pkg::op_hit_t hit,
    output eeg_cmd_pkg::act_ena_t act_ena,
    output logic                 info_vld
);

    import eeg_cmd_pkg::*;

    act_ena_t act_nxt;

    // ==============================
    // Opcode to hit strobes
    // ==============================
    always_comb begin
        hit = '0;
        if (cmd_vld) begin
            case (cmd_op)
                op_itoa:  hit.itoa     = 1'b1;
                op_itow:  hit.itow     = 1'b1;
                op_otoa:  hit.otoa     = 1'b1;
                op_atow:  hit.atow     = 1'b1;
                op_wtoa:  hit.wtoa     = 1'b1;
                op_conv:  hit.conv     = 1'b1;
                op_pool:  hit.pool     = 1'b1;
                op_stat:  hit.stat     = 1'b1;
                op_read:  hit.read     = 1'b1;
                inf_conv: hit.inf_conv = 1'b1;
                inf_aram: hit.inf_aram = 1'b1;
                inf_wram: hit.inf_wram = 1'b1;
                inf_oram: hit.inf_oram = 1'b1;
                // Reserved opcodes 9 to 11
                default:  hit = '0;
            endcase
        end
    end

    // Action part of the hits, all zero for info and reserved opcodes
    assign act_nxt = {hit.read, hit.stat, hit.pool, hit.conv, hit.wtoa,
                      hit.atow, hit.otoa, hit.itow, hit.itoa};

    // ==============================
    // Enables and info strobe
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_ena  <= '0;
            info_vld <= 1'b0;
        end else begin
            info_vld <= cmd_vld;
            // Every valid command reloads, so an info command clears the enables
            if (cmd_vld) begin
                act_ena <= act_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeg_cfg_pkg.sv
// Output widths are fixed by the command word format and must not be changed on their own
`default_nettype none

package eeg_cfg_pkg;

    // ==============================
    // Memory configuration widths
    // ==============================
    // Bank index is 4 bits for every RAM and for the output mux
    localparam int bank_idx_w  = 4;

    // 4k activation, 8k weight and 1k output words
    localparam int aram_add_w  = 12;
    localparam int wram_add_w  = 13;
    localparam int oram_add_w  = 10;

    // ==============================
    // Layer configuration widths
    // ==============================
    localparam int conv_ich_w  = 8;
    localparam int conv_och_w  = 8;
    localparam int conv_len_w  = 10;
    // Factors are log2 coded, 1/2/4/8
    localparam int dila_fac_w  = 2;
    localparam int strd_fac_w  = 2;
    localparam int conv_wei_w  = 3;
    localparam int splt_len_w  = 8;
    localparam int pool_len_w  = oram_add_w;
    localparam int pool_fac_w  = 2;

    // RAM selects, start addresses and lengths
    typedef struct packed {
        logic [bank_idx_w-1:0] aram_idx;
        logic [bank_idx_w-1:0] wram_idx;
        logic [bank_idx_w-1:0] oram_idx;
        logic [bank_idx_w-1:0] omux_idx;
        logic [aram_add_w-1:0] aram_add;
        logic [aram_add_w-1:0] aram_len;
        logic [wram_add_w-1:0] wram_add;
        logic [wram_add_w-1:0] wram_len;
        logic [oram_add_w-1:0] oram_add;
        logic [oram_add_w-1:0] oram_len;
    } mem_cfg_t;

    // Feature switches of the datapath
    typedef struct packed {
        logic relu;
        logic splt;
        logic comb;
        logic flag;
        logic maxp;
        logic avgp;
        logic resn;
        logic flag_vld;
        logic stat_vld;
        logic wbuf;
    } layer_flags_t;

    typedef struct packed {
        logic [conv_ich_w-1:0] conv_ich;
        logic [conv_och_w-1:0] conv_och;
        logic [conv_len_w-1:0] conv_len;
        logic [dila_fac_w-1:0] dila_fac;
        logic [strd_fac_w-1:0] strd_fac;
        logic [conv_wei_w-1:0] conv_wei;
        logic [splt_len_w-1:0] splt_len;
        logic [pool_len_w-1:0] pool_len;
        logic [pool_fac_w-1:0] pool_fac;
        layer_flags_t          flags;
    } layer_cfg_t;

endpackage

`default_nettype wire

// File: hdl/eeg_cmd_pkg.sv
// Fixed 32-bit command word with the opcode in bits 3:0; opcodes 9 to 11 are reserved and carry no fields
`default_nettype none

package eeg_cmd_pkg;

    // ==============================
    // Command word
    // ==============================
    localparam int cmd_word_w = 32;
    localparam int opcode_w   = 4;
    localparam int lsb_opcode = 0;

    typedef logic [cmd_word_w-1:0] cmd_word_t;

    // Action opcodes first, then the info opcodes that only load fields
    typedef enum logic [opcode_w-1:0] {
        op_itoa  = 4'd0,
        op_itow  = 4'd1,
        op_otoa  = 4'd2,
        op_atow  = 4'd3,
        op_wtoa  = 4'd4,
        op_conv  = 4'd5,
        op_pool  = 4'd6,
        op_stat  = 4'd7,
        op_read  = 4'd8,
        inf_conv = 4'd12,
        inf_aram = 4'd13,
        inf_wram = 4'd14,
        inf_oram = 4'd15
    } opcode_t;

    // ==============================
    // Field positions (low bit)
    // ==============================
    // ITOA, also OTOA/ATOW/WTOA/READ for the activation bank
    localparam int lsb_aram_idx  = 16;
    localparam int lsb_aram_add  = 20;
    localparam int lsb_aram_len  = 4;

    // ITOW
    localparam int wram_sel_w    = 2;
    localparam int lsb_wram_sel  = 17;
    localparam int lsb_wram_add  = 19;
    localparam int lsb_wram_len  = 4;

    // OTOA
    localparam int lsb_omux_idx  = 12;
    localparam int lsb_oram_idx  = 8;
    localparam int lsb_splt_len  = 24;
    localparam int bit_relu      = 20;
    localparam int bit_splt      = 21;
    localparam int bit_comb      = 22;
    localparam int bit_flag      = 23;

    // ATOW, WTOA and READ
    localparam int lsb_wram_idx  = 12;

    // CONV
    localparam int lsb_strd_fac  = 4;
    localparam int lsb_dila_fac  = 6;
    localparam int lsb_conv_wei  = 8;
    localparam int bit_conv_mode = 11;

    // POOL
    localparam int lsb_pool_len  = 4;
    localparam int lsb_pool_fac  = 14;
    localparam int bit_maxp      = 16;
    localparam int bit_avgp      = 17;

    // INF_CONV and INF_ORAM
    localparam int lsb_conv_ich  = 4;
    localparam int lsb_conv_och  = 12;
    localparam int lsb_conv_len  = 20;
    localparam int lsb_oram_add  = 22;
    localparam int lsb_oram_len  = 4;

    // One strobe per opcode, set only for a valid command
    typedef struct packed {
        logic inf_oram;
        logic inf_wram;
        logic inf_aram;
        logic inf_conv;
        logic read;
        logic stat;
        logic pool;
        logic conv;
        logic wtoa;
        logic atow;
        logic otoa;
        logic itow;
        logic itoa;
    } op_hit_t;

    typedef struct packed {
        logic read;
        logic stat;
        logic pool;
        logic conv;
        logic wtoa;
        logic atow;
        logic otoa;
        logic itow;
        logic itoa;
    } act_ena_t;

endpackage

`default_nettype wire
